// File: logic/tlb_cfg.svh
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// number of TLB entries, index width follows from it
`define TLB_ENTRIES 32

// memory access type used while address translation is off
`define TLB_DA_MAT 2'd1

// supported page size codes
`define TLB_PS_4K 6'd12
`define TLB_PS_2M 6'd21

`endif

// File: logic/tlb_pkg.sv
package tlb_pkg;

    // same encoding as the core pipeline
    typedef enum logic [1:0] {
        MEM_LOAD  = 2'd0,
        MEM_STORE = 2'd1,
        MEM_FETCH = 2'd2
    } mem_type_t;

    typedef enum logic [1:0] {
        MODE_DIRECT = 2'b01,
        MODE_MAPPED = 2'b10
    } tr_mode_t;

    typedef enum logic [2:0] {
        INV_ALL          = 3'd0,
        INV_ALL_ALT      = 3'd1,
        INV_GLOBAL       = 3'd2,
        INV_LOCAL        = 3'd3,
        INV_LOCAL_ASID   = 3'd4,
        INV_LOCAL_ASID_VA = 3'd5,
        INV_ASID_VA      = 3'd6
    } invtlb_op_t;

    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [9:0]  asid;
        logic [5:0]  ps;
        logic        e;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    // direct mapping window view of a virtual address
    typedef struct packed {
        logic [2:0]  vseg;
        logic [28:0] rest;
    } va_dmw_t;

    // 4 KB page view of a virtual address
    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] offset;
    } va_page_t;

    typedef union packed {
        va_dmw_t  dmw;
        va_page_t page;
    } va_view_t;

    typedef struct packed {
        logic      en;
        va_view_t  va;
        logic [9:0] asid;
        logic [1:0] plv;
        mem_type_t mem_type;
    } lookup_req_t;

    typedef struct packed {
        logic ade;
        logic tlbr;
        logic pif;
        logic pil;
        logic pis;
        logic ppi;
        logic pme;
    } exc_flags_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic [1:0]  mat;
        exc_flags_t  exc;
    } lookup_rsp_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic      hit;
        logic [5:0] ps;
        tlb_page_t page;
    } match_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] paddr;
        logic [1:0]  mat;
    } dmw_hit_t;

endpackage

// File: logic/tlb_entry_array.sv
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_entry_array #(
    localparam int IDX_W = $clog2(`TLB_ENTRIES)
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 we,
    input  logic [IDX_W-1:0]     w_index,
    input  tlb_pkg::tlb_entry_t  w_entry,

    input  logic                 inv_en,
    input  tlb_pkg::invtlb_op_t  inv_op,
    input  logic [9:0]           inv_asid,
    input  tlb_pkg::va_view_t    inv_va,

    input  logic [IDX_W-1:0]     r_index,
    output tlb_pkg::tlb_entry_t  r_entry,
    output tlb_pkg::tlb_entry_t  entries [`TLB_ENTRIES]
);

    tlb_pkg::tlb_entry_t mem [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] inv_sel;

    // INVTLB selection per entry
    always_comb begin
        logic asid_eq;
        logic vpn_eq;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            asid_eq = mem[i].asid == inv_asid;
            // huge pages only compare the upper vpn2 bits
            if (mem[i].ps == `TLB_PS_4K) begin
                vpn_eq = mem[i].vpn2 == inv_va.page.vpn2;
            end else begin
                vpn_eq = mem[i].vpn2[18:9] == inv_va.page.vpn2[18:9];
            end
            case (inv_op)
                tlb_pkg::INV_ALL,
                tlb_pkg::INV_ALL_ALT:       inv_sel[i] = 1'b1;
                tlb_pkg::INV_GLOBAL:        inv_sel[i] = mem[i].g;
                tlb_pkg::INV_LOCAL:         inv_sel[i] = !mem[i].g;
                tlb_pkg::INV_LOCAL_ASID:    inv_sel[i] = !mem[i].g && asid_eq;
                tlb_pkg::INV_LOCAL_ASID_VA: inv_sel[i] = !mem[i].g && asid_eq && vpn_eq;
                tlb_pkg::INV_ASID_VA:       inv_sel[i] = (mem[i].g || asid_eq) && vpn_eq;
                default:                    inv_sel[i] = 1'b0;
            endcase
        end
    end

    // write beats invalidate on its own index
    always_ff @(posedge clk) begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (reset) begin
                mem[i].e <= 1'b0;
            end else if (we && w_index == IDX_W'(i)) begin
                mem[i] <= w_entry;
            end else if (inv_en && inv_sel[i]) begin
                mem[i].e <= 1'b0;
            end
        end
    end

    assign r_entry = mem[r_index];
    assign entries = mem;

    inv_op_legal: assert property (
        @(posedge clk) disable iff (reset)
        inv_en |-> inv_op <= tlb_pkg::INV_ASID_VA
    ) else $error("INVTLB op %0d out of range", inv_op);

    // matcher and compose only know the two page sizes
    write_ps_legal: assert property (
        @(posedge clk) disable iff (reset)
        (we && w_entry.e) |-> (w_entry.ps == `TLB_PS_4K || w_entry.ps == `TLB_PS_2M)
    ) else $error("TLB write with unsupported ps %0d", w_entry.ps);

endmodule

// File: logic/tlb_match.sv
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_match #(
    localparam int IDX_W = $clog2(`TLB_ENTRIES)
) (
    input  tlb_pkg::tlb_entry_t  entries [`TLB_ENTRIES],

    input  tlb_pkg::lookup_req_t s0,
    input  tlb_pkg::lookup_req_t s1,
    output tlb_pkg::match_t      m0,
    output tlb_pkg::match_t      m1,

    input  logic [18:0]          s_vpn2,
    input  logic [9:0]           s_asid,
    output logic                 s_hit,
    output logic [IDX_W-1:0]     s_index
);

    logic [`TLB_ENTRIES-1:0] hit0;
    logic [`TLB_ENTRIES-1:0] hit1;
    logic [`TLB_ENTRIES-1:0] hit_s;

    function automatic logic entry_hit(tlb_pkg::tlb_entry_t ent, logic [18:0] vpn2,
                                       logic [9:0] asid);
        logic vpn_eq;
        if (ent.ps == `TLB_PS_4K) begin
            vpn_eq = ent.vpn2 == vpn2;
        end else begin
            vpn_eq = ent.vpn2[18:9] == vpn2[18:9];
        end
        return ent.e && (ent.g || ent.asid == asid) && vpn_eq;
    endfunction

    // odd/even half of a hit entry
    function automatic tlb_pkg::match_t pick_page(tlb_pkg::tlb_entry_t ent,
                                                  tlb_pkg::va_view_t va);
        logic [31:0] a;
        logic odd;
        tlb_pkg::match_t m;
        a = va;
        odd = (ent.ps == `TLB_PS_4K) ? a[12] : a[21];
        m.hit = 1'b1;
        m.ps = ent.ps;
        m.page = odd ? ent.page1 : ent.page0;
        return m;
    endfunction

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hit0[i] = entry_hit(entries[i], s0.va.page.vpn2, s0.asid);
            hit1[i] = entry_hit(entries[i], s1.va.page.vpn2, s1.asid);
            hit_s[i] = entry_hit(entries[i], s_vpn2, s_asid);
        end
    end

    always_comb begin
        m0 = '0;
        m1 = '0;
        s_index = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hit0[i]) begin
                m0 = pick_page(entries[i], s0.va);
            end
            if (hit1[i]) begin
                m1 = pick_page(entries[i], s1.va);
            end
            if (hit_s[i]) begin
                s_index = IDX_W'(i);
            end
        end
    end

    assign s_hit = |hit_s;

    // duplicate entries would make the one-hot mux above meaningless
    always_comb begin
        assert ((!s0.en || $onehot0(hit0)) && (!s1.en || $onehot0(hit1)) && $onehot0(hit_s))
            else $error("multiple TLB entries hit one compare");
    end

endmodule

// File: logic/tlb_dmw_map.sv
`timescale 1ns/100ps

module tlb_dmw_map (
    input  tlb_pkg::dmw_cfg_t    dmw0,
    input  tlb_pkg::dmw_cfg_t    dmw1,
    input  tlb_pkg::lookup_req_t s0,
    input  tlb_pkg::lookup_req_t s1,
    output tlb_pkg::dmw_hit_t    d0,
    output tlb_pkg::dmw_hit_t    d1
);

    function automatic tlb_pkg::dmw_hit_t window(tlb_pkg::dmw_cfg_t cfg,
                                                 tlb_pkg::lookup_req_t req);
        tlb_pkg::dmw_hit_t h;
        logic plv_ok;
        plv_ok = (req.plv == 2'd0 && cfg.plv0) || (req.plv == 2'd3 && cfg.plv3);
        h.hit = plv_ok && req.va.dmw.vseg == cfg.vseg;
        // pseg replaces the top three bits
        h.paddr = {cfg.pseg, req.va.dmw.rest};
        h.mat = cfg.mat;
        return h;
    endfunction

    // window 0 first
    function automatic tlb_pkg::dmw_hit_t map(tlb_pkg::dmw_cfg_t cfg0,
                                              tlb_pkg::dmw_cfg_t cfg1,
                                              tlb_pkg::lookup_req_t req);
        tlb_pkg::dmw_hit_t w0;
        tlb_pkg::dmw_hit_t w1;
        w0 = window(cfg0, req);
        w1 = window(cfg1, req);
        return w0.hit ? w0 : w1;
    endfunction

    assign d0 = map(dmw0, dmw1, s0);
    assign d1 = map(dmw0, dmw1, s1);

endmodule

// File: logic/tlb_result_stage.sv
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_result_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  tlb_pkg::tr_mode_t    ad_mode,

    input  tlb_pkg::lookup_req_t s0,
    input  tlb_pkg::lookup_req_t s1,
    input  tlb_pkg::match_t      m0,
    input  tlb_pkg::match_t      m1,
    input  tlb_pkg::dmw_hit_t    d0,
    input  tlb_pkg::dmw_hit_t    d1,

    output tlb_pkg::lookup_rsp_t s0_rsp,
    output tlb_pkg::lookup_rsp_t s1_rsp
);

    tlb_pkg::lookup_req_t req_d [2];
    tlb_pkg::match_t      m_d   [2];
    tlb_pkg::dmw_hit_t    d_d   [2];
    tlb_pkg::lookup_rsp_t rsp   [2];

    // first failing check wins, only in mapped mode outside the windows
    function automatic tlb_pkg::exc_flags_t exc_of(tlb_pkg::lookup_req_t req,
                                                   tlb_pkg::match_t m,
                                                   logic dmw_hit, logic mapped);
        tlb_pkg::exc_flags_t exc;
        exc = '0;
        if (mapped && !dmw_hit) begin
            if (req.plv == 2'd3 && req.va.dmw.vseg[2]) begin
                exc.ade = 1'b1;
            end else if (!m.hit) begin
                exc.tlbr = 1'b1;
            end else if (!m.page.v) begin
                exc.pif = req.mem_type == tlb_pkg::MEM_FETCH;
                exc.pil = req.mem_type == tlb_pkg::MEM_LOAD;
                exc.pis = req.mem_type == tlb_pkg::MEM_STORE;
            end else if (req.plv > m.page.plv) begin
                exc.ppi = 1'b1;
            end else if (req.mem_type == tlb_pkg::MEM_STORE && !m.page.d) begin
                exc.pme = 1'b1;
            end
        end
        return exc;
    endfunction

    function automatic tlb_pkg::lookup_rsp_t respond(tlb_pkg::lookup_req_t req,
                                                     tlb_pkg::match_t m,
                                                     tlb_pkg::dmw_hit_t d,
                                                     tlb_pkg::tr_mode_t mode, logic en);
        tlb_pkg::lookup_rsp_t r;
        logic [31:0] va;
        logic mapped;
        va = req.va;
        mapped = mode != tlb_pkg::MODE_DIRECT;
        if (!mapped) begin
            r.paddr = va;
            r.mat = `TLB_DA_MAT;
        end else if (d.hit) begin
            r.paddr = d.paddr;
            r.mat = d.mat;
        end else begin
            if (m.ps == `TLB_PS_4K) begin
                r.paddr = {m.page.pfn, va[11:0]};
            end else begin
                r.paddr = {m.page.pfn[19:9], va[20:0]};
            end
            r.mat = m.page.mat;
        end
        r.exc = en ? exc_of(req, m, d.hit, mapped) : '0;
        return r;
    endfunction

    assign req_d[0] = s0;
    assign req_d[1] = s1;
    assign m_d[0] = m0;
    assign m_d[1] = m1;
    assign d_d[0] = d0;
    assign d_d[1] = d1;

    for (genvar p = 0; p < 2; p++) begin : g_port
        tlb_pkg::lookup_req_t req_q;
        tlb_pkg::match_t      m_q;
        tlb_pkg::dmw_hit_t    d_q;
        tlb_pkg::tr_mode_t    mode_q;
        logic                 en_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                en_q <= 1'b0;
                req_q <= '0;
                m_q <= '0;
                d_q <= '0;
                // mapped with a cleared miss composes an all-zero response
                mode_q <= tlb_pkg::MODE_MAPPED;
            end else begin
                en_q <= req_d[p].en;
                if (req_d[p].en) begin
                    req_q <= req_d[p];
                    m_q <= m_d[p];
                    d_q <= d_d[p];
                    mode_q <= ad_mode;
                end
            end
        end

        assign rsp[p] = respond(req_q, m_q, d_q, mode_q, en_q);

        mode_onehot: assert property (
            @(posedge clk) disable iff (reset)
            $onehot(mode_q)
        ) else $error("port %0d registered mode not one-hot", p);
    end

    assign s0_rsp = rsp[0];
    assign s1_rsp = rsp[1];

endmodule

// File: logic/tlb_translate.sv
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_translate #(
    localparam int IDX_W = $clog2(`TLB_ENTRIES)
) (
    input  logic                 clk,
    input  logic                 reset,

    // fetch and data lookup
    input  tlb_pkg::lookup_req_t s0,
    input  tlb_pkg::lookup_req_t s1,
    output tlb_pkg::lookup_rsp_t s0_rsp,
    output tlb_pkg::lookup_rsp_t s1_rsp,

    input  tlb_pkg::tr_mode_t    ad_mode,
    input  tlb_pkg::dmw_cfg_t    dmw0,
    input  tlb_pkg::dmw_cfg_t    dmw1,

    // TLBWR / TLBFILL
    input  logic                 we,
    input  logic [IDX_W-1:0]     w_index,
    input  tlb_pkg::tlb_entry_t  w_entry,

    // TLBRD
    input  logic [IDX_W-1:0]     r_index,
    output tlb_pkg::tlb_entry_t  r_entry,

    // TLBSRCH
    input  logic [18:0]          s_vpn2,
    input  logic [9:0]           s_asid,
    output logic                 s_hit,
    output logic [IDX_W-1:0]     s_index,

    // INVTLB
    input  logic                 inv_en,
    input  tlb_pkg::invtlb_op_t  inv_op,
    input  logic [9:0]           inv_asid,
    input  tlb_pkg::va_view_t    inv_va
);

    tlb_pkg::tlb_entry_t entries [`TLB_ENTRIES];
    tlb_pkg::match_t     m0;
    tlb_pkg::match_t     m1;
    tlb_pkg::dmw_hit_t   d0;
    tlb_pkg::dmw_hit_t   d1;

    tlb_entry_array u_array (
        .clk      (clk),
        .reset    (reset),
        .we       (we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .inv_en   (inv_en),
        .inv_op   (inv_op),
        .inv_asid (inv_asid),
        .inv_va   (inv_va),
        .r_index  (r_index),
        .r_entry  (r_entry),
        .entries  (entries)
    );

    tlb_match u_match (
        .entries (entries),
        .s0      (s0),
        .s1      (s1),
        .m0      (m0),
        .m1      (m1),
        .s_vpn2  (s_vpn2),
        .s_asid  (s_asid),
        .s_hit   (s_hit),
        .s_index (s_index)
    );

    tlb_dmw_map u_dmw (
        .dmw0 (dmw0),
        .dmw1 (dmw1),
        .s0   (s0),
        .s1   (s1),
        .d0   (d0),
        .d1   (d1)
    );

    tlb_result_stage u_result (
        .clk     (clk),
        .reset   (reset),
        .ad_mode (ad_mode),
        .s0      (s0),
        .s1      (s1),
        .m0      (m0),
        .m1      (m1),
        .d0      (d0),
        .d1      (d1),
        .s0_rsp  (s0_rsp),
        .s1_rsp  (s1_rsp)
    );

endmodule

// File: verification/tlb_checker.sv
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_checker #(
    localparam int IDX_W = $clog2(`TLB_ENTRIES)
) (
    input  logic                 clk,
    input  logic                 reset,
    input  int                   test_num,
    input  logic                 done,
    input  tlb_pkg::lookup_req_t s0,
    input  tlb_pkg::lookup_req_t s1,
    input  tlb_pkg::lookup_rsp_t s0_rsp,
    input  tlb_pkg::lookup_rsp_t s1_rsp,
    input  tlb_pkg::tr_mode_t    ad_mode,
    input  tlb_pkg::dmw_cfg_t    dmw0,
    input  tlb_pkg::dmw_cfg_t    dmw1,
    input  logic                 we,
    input  logic [IDX_W-1:0]     w_index,
    input  tlb_pkg::tlb_entry_t  w_entry,
    input  logic [IDX_W-1:0]     r_index,
    input  tlb_pkg::tlb_entry_t  r_entry,
    input  logic [18:0]          s_vpn2,
    input  logic [9:0]           s_asid,
    input  logic                 s_hit,
    input  logic [IDX_W-1:0]     s_index,
    input  logic                 inv_en,
    input  tlb_pkg::invtlb_op_t  inv_op,
    input  logic [9:0]           inv_asid,
    input  tlb_pkg::va_view_t    inv_va,
    output int                   errors,
    output int                   checks
);

    tlb_pkg::tlb_entry_t  mdl [`TLB_ENTRIES];
    logic                 written [`TLB_ENTRIES];
    tlb_pkg::lookup_rsp_t exp_rsp [2];
    logic                 exp_known [2];
    int                   cur_test;
    int                   test_checks;
    int                   test_errs;
    logic                 reported;

    initial begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            mdl[i] = '0;
            written[i] = 1'b0;
        end
        errors = 0;
        checks = 0;
        cur_test = 0;
        test_checks = 0;
        test_errs = 0;
        reported = 1'b0;
    end

    function automatic logic vpn_match(tlb_pkg::tlb_entry_t ent, logic [18:0] vpn2);
        if (ent.ps == `TLB_PS_4K) begin
            return ent.vpn2 == vpn2;
        end
        return ent.vpn2[18:9] == vpn2[18:9];
    endfunction

    function automatic logic ref_search(logic [18:0] vpn2, logic [9:0] asid,
                                        output logic [IDX_W-1:0] idx);
        logic hit;
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (mdl[i].e && (mdl[i].g || mdl[i].asid == asid) && vpn_match(mdl[i], vpn2)) begin
                hit = 1'b1;
                idx = IDX_W'(i);
            end
        end
        return hit;
    endfunction

    // known clear means only the flags are defined (miss)
    function automatic tlb_pkg::lookup_rsp_t ref_translate(tlb_pkg::lookup_req_t req,
                                                            output logic known);
        tlb_pkg::lookup_rsp_t r;
        tlb_pkg::tlb_page_t pg;
        logic [31:0] va;
        logic [IDX_W-1:0] k;
        logic found;
        logic odd;
        r = '0;
        pg = '0;
        known = 1'b1;
        va = req.va;
        if (ad_mode == tlb_pkg::MODE_DIRECT) begin
            r.paddr = va;
            r.mat = `TLB_DA_MAT;
            return r;
        end
        if (((req.plv == 2'd0 && dmw0.plv0) || (req.plv == 2'd3 && dmw0.plv3))
                && va[31:29] == dmw0.vseg) begin
            r.paddr = {dmw0.pseg, va[28:0]};
            r.mat = dmw0.mat;
            return r;
        end
        if (((req.plv == 2'd0 && dmw1.plv0) || (req.plv == 2'd3 && dmw1.plv3))
                && va[31:29] == dmw1.vseg) begin
            r.paddr = {dmw1.pseg, va[28:0]};
            r.mat = dmw1.mat;
            return r;
        end
        found = ref_search(va[31:13], req.asid, k);
        if (found) begin
            odd = (mdl[k].ps == `TLB_PS_4K) ? va[12] : va[21];
            pg = odd ? mdl[k].page1 : mdl[k].page0;
            if (mdl[k].ps == `TLB_PS_4K) begin
                r.paddr = {pg.pfn, va[11:0]};
            end else begin
                r.paddr = {pg.pfn[19:9], va[20:0]};
            end
            r.mat = pg.mat;
        end else begin
            known = 1'b0;
        end
        if (req.plv == 2'd3 && va[31]) begin
            r.exc.ade = 1'b1;
        end else if (!found) begin
            r.exc.tlbr = 1'b1;
        end else if (!pg.v) begin
            r.exc.pif = req.mem_type == tlb_pkg::MEM_FETCH;
            r.exc.pil = req.mem_type == tlb_pkg::MEM_LOAD;
            r.exc.pis = req.mem_type == tlb_pkg::MEM_STORE;
        end else if (req.plv > pg.plv) begin
            r.exc.ppi = 1'b1;
        end else if (req.mem_type == tlb_pkg::MEM_STORE && !pg.d) begin
            r.exc.pme = 1'b1;
        end
        return r;
    endfunction

    task automatic check_val(string name, logic [127:0] exp_v, logic [127:0] got_v);
        checks++;
        test_checks++;
        if (got_v !== exp_v) begin
            errors++;
            test_errs++;
            $display("ERR %s exp %h got %h", name, exp_v, got_v);
        end
    endtask

    task automatic check_rsp(string name, tlb_pkg::lookup_rsp_t got,
                             tlb_pkg::lookup_rsp_t exp_r, logic known);
        if (known) begin
            check_val(name, exp_r, got);
        end else begin
            check_val({name, ".exc"}, exp_r.exc, got.exc);
        end
    endtask

    always @(posedge clk) begin
        tlb_pkg::lookup_rsp_t nxt;
        logic kn;
        logic hit;
        logic sel;
        logic [IDX_W-1:0] idx;
        if (test_num != cur_test) begin
            if (cur_test != 0) begin
                $display("test %0d: %0d checks, %0d errors", cur_test, test_checks, test_errs);
            end
            cur_test = test_num;
            test_checks = 0;
            test_errs = 0;
        end
        if (reset) begin
            for (int p = 0; p < 2; p++) begin
                exp_rsp[p] = '0;
                exp_known[p] = 1'b1;
            end
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                mdl[i].e = 1'b0;
            end
        end else begin
            check_rsp("s0_rsp", s0_rsp, exp_rsp[0], exp_known[0]);
            check_rsp("s1_rsp", s1_rsp, exp_rsp[1], exp_known[1]);
            if (written[r_index]) begin
                check_val("r_entry", mdl[r_index], r_entry);
            end else begin
                check_val("r_entry.e", mdl[r_index].e, r_entry.e);
            end
            hit = ref_search(s_vpn2, s_asid, idx);
            check_val("s_hit", hit, s_hit);
            if (hit) begin
                check_val("s_index", idx, s_index);
            end

            // responses expected at the next edge
            if (s0.en) begin
                nxt = ref_translate(s0, kn);
                exp_rsp[0] = nxt;
                exp_known[0] = kn;
            end else begin
                exp_rsp[0].exc = '0;
            end
            if (s1.en) begin
                nxt = ref_translate(s1, kn);
                exp_rsp[1] = nxt;
                exp_known[1] = kn;
            end else begin
                exp_rsp[1].exc = '0;
            end

            if (inv_en) begin
                for (int i = 0; i < `TLB_ENTRIES; i++) begin
                    case (inv_op)
                        3'd0, 3'd1: sel = 1'b1;
                        3'd2: sel = mdl[i].g;
                        3'd3: sel = !mdl[i].g;
                        3'd4: sel = !mdl[i].g && mdl[i].asid == inv_asid;
                        3'd5: sel = !mdl[i].g && mdl[i].asid == inv_asid
                                    && vpn_match(mdl[i], inv_va.page.vpn2);
                        3'd6: sel = (mdl[i].g || mdl[i].asid == inv_asid)
                                    && vpn_match(mdl[i], inv_va.page.vpn2);
                        default: sel = 1'b0;
                    endcase
                    if (sel) begin
                        mdl[i].e = 1'b0;
                    end
                end
            end
            if (we) begin
                mdl[w_index] = w_entry;
                written[w_index] = 1'b1;
            end
        end
        if (done && !reported) begin
            $display("test %0d: %0d checks, %0d errors", cur_test, test_checks, test_errs);
            $display("total: %0d checks, %0d errors", checks, errors);
            reported = 1'b1;
        end
    end

endmodule

// File: verification/tlb_translate_tb.sv
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_translate_tb;

    localparam int IDX_W = $clog2(`TLB_ENTRIES);
    localparam int PERIOD = 100;
    localparam int LOOKUPS = 60;
    localparam int INV_LOOKUPS = 16;
    localparam int STIM_CYCLES = 8 + `TLB_ENTRIES + 40 + 40
                                 + 2 * (`TLB_ENTRIES + 1 + LOOKUPS)
                                 + 7 * (`TLB_ENTRIES + 2 + INV_LOOKUPS) + 4;
    localparam int MARGIN = 100;

    logic                 clk;
    logic                 reset;
    tlb_pkg::lookup_req_t s0;
    tlb_pkg::lookup_req_t s1;
    tlb_pkg::lookup_rsp_t s0_rsp;
    tlb_pkg::lookup_rsp_t s1_rsp;
    tlb_pkg::tr_mode_t    ad_mode;
    tlb_pkg::dmw_cfg_t    dmw0;
    tlb_pkg::dmw_cfg_t    dmw1;
    logic                 we;
    logic [IDX_W-1:0]     w_index;
    tlb_pkg::tlb_entry_t  w_entry;
    logic [IDX_W-1:0]     r_index;
    tlb_pkg::tlb_entry_t  r_entry;
    logic [18:0]          s_vpn2;
    logic [9:0]           s_asid;
    logic                 s_hit;
    logic [IDX_W-1:0]     s_index;
    logic                 inv_en;
    tlb_pkg::invtlb_op_t  inv_op;
    logic [9:0]           inv_asid;
    tlb_pkg::va_view_t    inv_va;

    int                   seed;
    int                   test_num;
    logic                 done;
    int                   errors;
    int                   checks;
    // what was written, for aiming lookups at real entries
    logic [18:0]          vpn_tab [`TLB_ENTRIES];
    logic [9:0]           asid_tab [`TLB_ENTRIES];
    logic [5:0]           ps_tab [`TLB_ENTRIES];

    tlb_translate UUT (.*);

    tlb_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(longint'(STIM_CYCLES + MARGIN) * PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("Checks failed");
        $finish;
    end

    // vpn2 bits 13..9 carry the index so no two entries can overlap
    function automatic tlb_pkg::tlb_entry_t rand_entry(int idx, logic valid_only);
        tlb_pkg::tlb_entry_t ent;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        r = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        ent.vpn2 = {r[4:0], idx[4:0], r[13:5]};
        ent.asid = {8'h0, r[15:14]};
        ent.ps = r[16] ? `TLB_PS_2M : `TLB_PS_4K;
        ent.e = 1'b1;
        ent.g = r[17] & r[18];
        ent.page0 = r2[25:0];
        ent.page1 = r3[25:0];
        if (valid_only) begin
            ent.page0.v = 1'b1;
            ent.page0.d = 1'b1;
            ent.page0.plv = 2'd3;
            ent.page1.v = 1'b1;
            ent.page1.d = 1'b1;
            ent.page1.plv = 2'd3;
        end
        return ent;
    endfunction

    function automatic tlb_pkg::lookup_req_t rand_req(logic any_plv);
        tlb_pkg::lookup_req_t req;
        logic [31:0] r;
        logic [31:0] r2;
        int k;
        r = $random(seed);
        r2 = $random(seed);
        k = int'(r[20:16]);
        req.en = r[3:0] != 4'd0;
        if (r[5:4] == 2'd0) begin
            req.va = r2;
        end else if (ps_tab[k] == `TLB_PS_4K) begin
            req.va = {vpn_tab[k], r2[12:0]};
        end else begin
            req.va = {vpn_tab[k][18:9], r2[21:0]};
        end
        req.asid = r[7] ? asid_tab[k] : {8'h0, r[9:8]};
        req.plv = any_plv ? r[11:10] : 2'd0;
        req.mem_type = tlb_pkg::mem_type_t'(2'($unsigned(r[15:12]) % 3));
        return req;
    endfunction

    task automatic write_all(logic valid_only);
        tlb_pkg::tlb_entry_t ent;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            @(negedge clk);
            ent = rand_entry(i, valid_only);
            vpn_tab[i] = ent.vpn2;
            asid_tab[i] = ent.asid;
            ps_tab[i] = ent.ps;
            we = 1'b1;
            w_index = IDX_W'(i);
            w_entry = ent;
        end
        @(negedge clk);
        we = 1'b0;
    endtask

    // both ports plus a read and a search every cycle
    task automatic lookups(int n, logic any_plv);
        logic [31:0] r;
        int k;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            inv_en = 1'b0;
            r = $random(seed);
            k = int'(r[4:0]);
            s0 = rand_req(any_plv);
            s1 = rand_req(any_plv);
            r_index = r[9:5];
            s_vpn2 = r[10] ? vpn_tab[k] : 19'($random(seed));
            s_asid = r[11] ? asid_tab[k] : {8'h0, r[13:12]};
        end
    endtask

    initial begin
        logic [31:0] r;
        seed = 32'hccf2_16a4;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            vpn_tab[i] = '0;
            asid_tab[i] = '0;
            ps_tab[i] = `TLB_PS_4K;
        end
        reset = 1'b1;
        test_num = 0;
        done = 1'b0;
        s0 = '0;
        s1 = '0;
        ad_mode = tlb_pkg::MODE_DIRECT;
        dmw0 = '0;
        dmw1 = '0;
        we = 1'b0;
        w_index = '0;
        w_entry = '0;
        r_index = '0;
        s_vpn2 = '0;
        s_asid = '0;
        inv_en = 1'b0;
        inv_op = tlb_pkg::INV_ALL;
        inv_asid = '0;
        inv_va = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_num = 1;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            @(negedge clk);
            r_index = IDX_W'(i);
            s_vpn2 = 19'($random(seed));
        end

        test_num = 2;
        repeat (40) begin
            @(negedge clk);
            s0.en = 1'b1;
            s0.va = $random(seed);
            s1.en = ($random(seed) & 3) != 0;
            s1.va = $random(seed);
        end

        test_num = 3;
        ad_mode = tlb_pkg::MODE_MAPPED;
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            r = $random(seed);
            if (i % 8 == 0) begin
                dmw0 = 10'($random(seed));
                dmw1 = 10'($random(seed));
                // same vseg on both windows to see window 0 win
                if (r[31]) begin
                    dmw1.vseg = dmw0.vseg;
                end
            end
            s0 = rand_req(1'b1);
            s1 = rand_req(1'b1);
            s0.va.dmw.vseg = r[0] ? dmw0.vseg : (r[1] ? dmw1.vseg : r[4:2]);
            s1.va.dmw.vseg = r[5] ? dmw1.vseg : r[8:6];
            s0.plv = {r[9], r[10] | r[9]};
        end

        test_num = 4;
        dmw0 = '0;
        dmw1 = '0;
        write_all(1'b1);
        lookups(LOOKUPS, 1'b0);

        test_num = 5;
        write_all(1'b0);
        lookups(LOOKUPS, 1'b1);

        test_num = 6;
        for (int op = 0; op < 7; op++) begin
            write_all(1'b0);
            @(negedge clk);
            r = $random(seed);
            inv_en = 1'b1;
            inv_op = tlb_pkg::invtlb_op_t'(3'(op));
            inv_asid = r[0] ? asid_tab[r[5:1]] : {8'h0, r[7:6]};
            inv_va = {vpn_tab[r[12:8]], r[24:12]};
            lookups(INV_LOOKUPS, 1'b1);
        end

        @(negedge clk);
        s0.en = 1'b0;
        s1.en = 1'b0;
        done = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tlb_translate.f
+incdir+logic
logic/tlb_pkg.sv
logic/tlb_entry_array.sv
logic/tlb_match.sv
logic/tlb_dmw_map.sv
logic/tlb_result_stage.sv
logic/tlb_translate.sv
verification/tlb_checker.sv
verification/tlb_translate_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tlb_translate_tb
FILELIST = tlb_translate.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
